/* Makefile */
# Verilator flow for the st_video testbench; every variable can be set on the command line

VERILATOR ?= verilator
TOP       ?= st_video_tb
FLIST     ?= st_video.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_FLAGS ?= +verilator+error+limit+1000
PASS_MSG  ?= sim passed
SOURCES   := $(wildcard source/*.sv test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* source/st_video.sv */
// top level of the mono video controller; connects timing, fetch, shifter and register bank
`timescale 1ns/1ps

module st_video #(
	parameter int h_active   = 640,
	parameter int v_active   = 400,
	parameter int h_prefetch = 16,
	parameter int h_front    = 24,
	parameter int h_sync     = 40,
	parameter int h_back     = 128,
	parameter int v_front    = 55,
	parameter int v_sync     = 3,
	parameter int v_back     = 73
) (
	input  logic                   clk,
	input  logic                   ss,
	input  st_video_pkg::word_t    mem_data,
	input  logic                   reg_sel,
	input  logic                   reg_rw,
	input  logic [5:0]             reg_addr,
	input  st_video_pkg::word_t    reg_din,
	output logic                   mem_read,
	output st_video_pkg::vaddr_t   vaddr,
	output st_video_pkg::word_t    reg_dout,
	output logic                   de,
	output logic                   hs,
	output logic                   vs,
	output st_video_pkg::colour_t  video_r,
	output st_video_pkg::colour_t  video_g,
	output st_video_pkg::colour_t  video_b
);

	import st_video_pkg::*;

	count_t hcnt;
	count_t vcnt;
	logic   hsync;
	logic   vsync;
	logic   frame_end;
	word_t  word;
	vaddr_t base;
	logic   invert;

	// line marker only feeds frame_end inside the timing block
	video_timing #(
		.h_active(h_active), .v_active(v_active), .h_prefetch(h_prefetch),
		.h_front(h_front), .h_sync(h_sync), .h_back(h_back),
		.v_front(v_front), .v_sync(v_sync), .v_back(v_back)
	) u_timing (
		.clk(clk), .ss(ss), .hcnt(hcnt), .vcnt(vcnt), .hsync(hsync), .vsync(vsync),
		.line_end(), .frame_end(frame_end)
	);

	video_fetch #(
		.h_active(h_active), .v_active(v_active), .h_prefetch(h_prefetch)
	) u_fetch (
		.clk(clk), .ss(ss), .hcnt(hcnt), .vcnt(vcnt), .frame_end(frame_end), .base(base),
		.mem_data(mem_data), .mem_read(mem_read), .vaddr(vaddr), .word(word)
	);

	video_shifter #(
		.h_active(h_active), .v_active(v_active), .h_prefetch(h_prefetch)
	) u_shifter (
		.clk(clk), .ss(ss), .hcnt(hcnt), .vcnt(vcnt), .hsync(hsync), .vsync(vsync),
		.word(word), .invert(invert), .de(de), .hs(hs), .vs(vs),
		.video_r(video_r), .video_g(video_g), .video_b(video_b)
	);

	// live counter goes back in for read-back
	video_regs u_regs (
		.clk(clk), .ss(ss), .reg_sel(reg_sel), .reg_rw(reg_rw), .reg_addr(reg_addr),
		.reg_din(reg_din), .vaddr(vaddr), .reg_dout(reg_dout), .base(base), .invert(invert)
	);

endmodule

/* source/st_video_pkg.sv */
// shared types, reset constants and register map of the mono video controller; imported by all RTL
package st_video_pkg;

	// horizontal or vertical pixel position
	typedef logic [9:0] count_t;

	// one video memory word, sixteen pixels
	typedef logic [15:0] word_t;

	// video word address
	typedef logic [22:0] vaddr_t;

	// one colour channel towards the dac
	typedef logic [5:0] colour_t;

	// palette entry 0
	// blue bit 0 doubles as the mono invert bit
	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [2:0] blue;
	} pal_t;

	// screen base after reset, word address
	localparam vaddr_t BASE_ADDR = 23'h008000;

	// fixed by the width of word_t
	localparam int PIXELS_PER_WORD = 16;

	// register select/read-write bus address map
	typedef enum logic [5:0] {
		REG_BASE_HI  = 6'h00,
		REG_BASE_MID = 6'h01,
		REG_CNT_HI   = 6'h02,
		REG_CNT_MID  = 6'h03,
		REG_CNT_LO   = 6'h04,
		REG_PALETTE0 = 6'h20
	} reg_addr_e;

endpackage

/* source/video_fetch.sv */
// memory fetch stage; requests one word per sixteen active pixels and hands it to the shifter
`timescale 1ns/1ps

module video_fetch #(
	parameter int h_active   = 640,
	parameter int v_active   = 400,
	parameter int h_prefetch = 16
) (
	input  logic                  clk,
	input  logic                  ss,
	input  st_video_pkg::count_t  hcnt,
	input  st_video_pkg::count_t  vcnt,
	input  logic                  frame_end,
	input  st_video_pkg::vaddr_t  base,
	input  st_video_pkg::word_t   mem_data,
	output logic                  mem_read,
	output st_video_pkg::vaddr_t  vaddr,
	output st_video_pkg::word_t   word
);

	import st_video_pkg::*;

	// fetch runs h_prefetch pixels ahead of the display window
	localparam count_t fetch_stop  = count_t'(h_active);
	localparam count_t fetch_lines = count_t'(v_active);

	logic read_q;

	// one read at the start of every word slot
	// prefetch distance equals one word of pixels
	assign mem_read = (hcnt < fetch_stop) && ((hcnt % h_prefetch) == 0) &&
		(vcnt < fetch_lines);

	// address counter
	// reset value matches the reset value of base in the register bank
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			read_q <= 1'b0;
			vaddr  <= BASE_ADDR;
		end else begin
			// data shows up one cycle after the request
			read_q <= mem_read;
			if (frame_end) begin
				vaddr <= base;
			end else if (mem_read) begin
				vaddr <= vaddr + 1'b1;
			end
		end
	end

	// holding register, filled at the end of the data cycle
	// next request may already be out while this one waits for the shifter
	always_ff @(posedge clk) begin
		if (read_q) begin
			word <= mem_data;
		end
	end

endmodule

/* source/video_regs.sv */
// register bank on the select/read-write bus; holds screen base and palette 0, reads back the counter
`timescale 1ns/1ps

module video_regs (
	input  logic                  clk,
	input  logic                  ss,
	input  logic                  reg_sel,
	input  logic                  reg_rw,
	input  logic [5:0]            reg_addr,
	input  st_video_pkg::word_t   reg_din,
	input  st_video_pkg::vaddr_t  vaddr,
	output st_video_pkg::word_t   reg_dout,
	output st_video_pkg::vaddr_t  base,
	output logic                  invert
);

	import st_video_pkg::*;

	reg_addr_e addr;
	logic [7:0] base_hi;
	logic [7:0] base_mid;
	pal_t       pal0;

	assign addr = reg_addr_e'(reg_addr);

	// base is aligned to 128 words, low bits not stored
	assign base   = {base_hi, base_mid, 7'b0000000};
	assign invert = pal0.blue[0];

	// writes on the clock edge with rw low
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			base_hi  <= BASE_ADDR[22:15];
			base_mid <= BASE_ADDR[14:7];
			// blue 7 means inverted mono, dark pixels for set bits
			pal0     <= '{red: 3'd0, green: 3'd0, blue: 3'b111};
		end else if (reg_sel && !reg_rw) begin
			case (addr)
				REG_BASE_HI:  base_hi <= reg_din[7:0];
				REG_BASE_MID: base_mid <= reg_din[7:0];
				REG_PALETTE0: begin
					pal0 <= '{red: reg_din[10:8], green: reg_din[6:4], blue: reg_din[2:0]};
				end
				// counter registers are read only
				default: ;
			endcase
		end
	end

	// read mux, zero outside a read cycle
	always_comb begin
		reg_dout = '0;
		if (reg_sel && reg_rw) begin
			case (addr)
				REG_BASE_HI:  reg_dout = {8'h00, base_hi};
				REG_BASE_MID: reg_dout = {8'h00, base_mid};
				REG_CNT_HI:   reg_dout = {8'h00, vaddr[22:15]};
				REG_CNT_MID:  reg_dout = {8'h00, vaddr[14:7]};
				// low counter bits sit one up, as on the original chip
				REG_CNT_LO:   reg_dout = {8'h00, vaddr[6:0], 1'b0};
				REG_PALETTE0: begin
					reg_dout = {5'h00, pal0.red, 1'b0, pal0.green, 1'b0, pal0.blue};
				end
				// unmapped reads return zero
				default:      reg_dout = '0;
			endcase
		end
	end

endmodule

/* source/video_shifter.sv */
// pixel shifter stage; serialises fetched words and registers display enable, sync and colours
`timescale 1ns/1ps

module video_shifter #(
	parameter int h_active   = 640,
	parameter int v_active   = 400,
	parameter int h_prefetch = 16
) (
	input  logic                   clk,
	input  logic                   ss,
	input  st_video_pkg::count_t   hcnt,
	input  st_video_pkg::count_t   vcnt,
	input  logic                   hsync,
	input  logic                   vsync,
	input  st_video_pkg::word_t    word,
	input  logic                   invert,
	output logic                   de,
	output logic                   hs,
	output logic                   vs,
	output st_video_pkg::colour_t  video_r,
	output st_video_pkg::colour_t  video_g,
	output st_video_pkg::colour_t  video_b
);

	import st_video_pkg::*;

	// visible window, delayed by the prefetch
	localparam count_t de_start = count_t'(h_prefetch);
	localparam count_t de_stop  = count_t'(h_active + h_prefetch);
	localparam count_t de_lines = count_t'(v_active);

	word_t   shreg;
	logic    en;
	logic    pixel;
	colour_t level;

	assign en = (hcnt >= de_start) && (hcnt < de_stop) && (vcnt < de_lines);

	// msb first
	assign pixel = shreg[PIXELS_PER_WORD - 1] ^ invert;

	// reload in the last pixel of a slot, shift otherwise
	always_ff @(posedge clk) begin
		if ((hcnt % PIXELS_PER_WORD) == PIXELS_PER_WORD - 1) begin
			shreg <= word;
		end else begin
			shreg <= shreg << 1;
		end
	end

	// output register, one cycle behind the counters
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			de    <= 1'b0;
			hs    <= 1'b1;
			vs    <= 1'b1;
			level <= '0;
		end else begin
			de    <= en;
			// syncs leave active low
			hs    <= ~hsync;
			vs    <= ~vsync;
			// black outside the window
			level <= {$bits(colour_t){en & pixel}};
		end
	end

	// mono, all channels equal
	assign video_r = level;
	assign video_g = level;
	assign video_b = level;

endmodule

/* source/video_timing.sv */
// raster timing generator; counts pixels and lines and decodes sync and end markers for later stages
`timescale 1ns/1ps

module video_timing #(
	parameter int h_active   = 640,
	parameter int v_active   = 400,
	parameter int h_prefetch = 16,
	parameter int h_front    = 24,
	parameter int h_sync     = 40,
	parameter int h_back     = 128,
	parameter int v_front    = 55,
	parameter int v_sync     = 3,
	parameter int v_back     = 73
) (
	input  logic                  clk,
	input  logic                  ss,
	output st_video_pkg::count_t  hcnt,
	output st_video_pkg::count_t  vcnt,
	output logic                  hsync,
	output logic                  vsync,
	output logic                  line_end,
	output logic                  frame_end
);

	import st_video_pkg::*;

	// last count of a line and of a frame
	localparam count_t h_last = count_t'(h_active + h_front + h_sync + h_back - 1);
	localparam count_t v_last = count_t'(v_active + v_front + v_sync + v_back - 1);

	// hsync window, shifted by the prefetch so it lines up with the shifted pixels
	localparam count_t hs_start = count_t'(h_active + h_front + h_prefetch);
	localparam count_t hs_stop  = count_t'(h_active + h_front + h_prefetch + h_sync);

	// vsync window in lines
	localparam count_t vs_start = count_t'(v_active + v_front);
	localparam count_t vs_stop  = count_t'(v_active + v_front + v_sync);

	// pixel and line counters
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (hcnt == h_last) begin
			hcnt <= '0;
			// line wrap advances the line counter
			if (vcnt == v_last) begin
				vcnt <= '0;
			end else begin
				vcnt <= vcnt + 1'b1;
			end
		end else begin
			hcnt <= hcnt + 1'b1;
		end
	end

	// sync pulses, active high here
	// the shifter inverts them for the outputs
	assign hsync = (hcnt >= hs_start) && (hcnt < hs_stop);
	assign vsync = (vcnt >= vs_start) && (vcnt < vs_stop);

	// end markers well behind the visible area
	// address reload happens here with no fetch pending
	assign line_end  = (hcnt == hs_start);
	assign frame_end = line_end && (vcnt == vs_start);

endmodule

/* st_video.f */
source/st_video_pkg.sv
source/video_timing.sv
source/video_regs.sv
source/video_fetch.sv
source/video_shifter.sv
source/st_video.sv
test/st_video_assertions.sv
test/st_video_tb.sv

/* test/st_video_assertions.sv */
// fetch stage checks, bound into every video_fetch instance; the testbench reads the failure count
`timescale 1ns/1ps

module st_video_assertions #(
	parameter int h_active = 640,
	parameter int v_active = 400
) (
	input logic                  clk,
	input logic                  ss,
	input st_video_pkg::count_t  hcnt,
	input st_video_pkg::count_t  vcnt,
	input logic                  frame_end,
	input st_video_pkg::vaddr_t  base,
	input logic                  mem_read,
	input st_video_pkg::vaddr_t  vaddr
);

	import st_video_pkg::*;

	int fails = 0;

	// one request per word slot, only inside the fetch window
	a_read_slot: assert property (@(posedge clk) disable iff (ss)
		mem_read |-> ((hcnt % PIXELS_PER_WORD) == 0) && (hcnt < h_active) && (vcnt < v_active))
		else begin
			fails++;
			$error("mem_read outside a word slot of the fetch window");
		end

	// reload takes the base seen at the frame_end edge
	a_reload: assert property (@(posedge clk) disable iff (ss)
		frame_end |=> (vaddr == $past(base)))
		else begin
			fails++;
			$error("vaddr not reloaded from base after frame_end");
		end

	// counter only moves on a read or a reload
	a_steady: assert property (@(posedge clk) disable iff (ss)
		(vaddr != $past(vaddr)) |-> $past(mem_read || frame_end))
		else begin
			fails++;
			$error("vaddr changed without a read or frame_end");
		end

endmodule

// window sizes follow the bound fetch stage
bind video_fetch st_video_assertions #(.h_active(h_active), .v_active(v_active)) u_fetch_checks (
	.clk(clk), .ss(ss), .hcnt(hcnt), .vcnt(vcnt), .frame_end(frame_end), .base(base),
	.mem_read(mem_read), .vaddr(vaddr)
);

/* test/st_video_tb.sv */
// testbench for the mono video controller; memory, register bus and pixel model, built from st_video.f
`timescale 1ns/1ps

module st_video_tb;

	import st_video_pkg::*;

	logic       clk, ss, reg_sel, reg_rw, mem_read, de, hs, vs, rd_q, exp_inv;
	logic [5:0] reg_addr;
	word_t      mem_data, reg_din, reg_dout;
	vaddr_t     vaddr, rd_addr, exp_base, frame_first;
	colour_t    video_r, video_g, video_b;
	word_t      mem_table [4096];
	int         errors, mark, tests, frame_pix, frame_runs, frame_reads, bad_runs, bad_lines;

	// small raster of 96 cycles per line and 16 lines per frame
	st_video #(
		.h_active(64), .v_active(8), .h_front(8), .h_sync(8), .h_back(16),
		.v_front(3), .v_sync(2), .v_back(3)
	) u_st_video (
		.clk(clk), .ss(ss), .mem_data(mem_data), .reg_sel(reg_sel), .reg_rw(reg_rw),
		.reg_addr(reg_addr), .reg_din(reg_din), .mem_read(mem_read), .vaddr(vaddr),
		.reg_dout(reg_dout), .de(de), .hs(hs), .vs(vs),
		.video_r(video_r), .video_g(video_g), .video_b(video_b)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// video memory answers a request seen on one falling edge on the next
	always @(negedge clk) begin
		rd_q    <= mem_read;
		rd_addr <= vaddr;
		if (rd_q)
			mem_data <= mem_table[rd_addr[11:0]];
	end

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input vaddr_t got, input vaddr_t exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_colour(input string name, input colour_t got, input colour_t exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	// cycle and pulse counts seen on the outputs
	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			errors++;
			$display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == mark)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: %0d errors", tests, name, errors - mark);
		mark = errors;
	endtask

	task automatic reg_write(input logic [5:0] addr, input word_t data);
		@(negedge clk);
		reg_sel  = 1'b1;
		reg_rw   = 1'b0;
		reg_addr = addr;
		reg_din  = data;
		@(negedge clk);
		reg_sel  = 1'b0;
		reg_rw   = 1'b1;
	endtask

	// combinational read data taken once it has settled
	task automatic reg_read(input logic [5:0] addr, output word_t data);
		@(negedge clk);
		reg_sel  = 1'b1;
		reg_rw   = 1'b1;
		reg_addr = addr;
		#1;
		data = reg_dout;
		@(negedge clk);
		reg_sel  = 1'b0;
	endtask

	// new screen base and invert with the base kept to 128 word steps
	task automatic set_regs(input vaddr_t b, input logic inv);
		reg_write(REG_BASE_HI, {8'h00, b[22:15]});
		reg_write(REG_BASE_MID, {8'h00, b[14:7]});
		reg_write(REG_PALETTE0, {13'h0000, inv ? 3'b111 : 3'b110});
		exp_base = {b[22:7], 7'h00};
		exp_inv  = inv;
	endtask

	// bounded wait for vs to reach a level
	task automatic wait_vs(input logic level);
		int n;
		n = 0;
		while (vs !== level && n < 2000) begin
			@(negedge clk);
			n++;
		end
		if (vs !== level) begin
			$display("timeout: vs stuck at %b", vs);
			$display("sim failed");
			$finish;
		end
	endtask

	// ends just after a complete vsync so one frame_end has gone by
	task automatic next_frame();
		wait_vs(1'b1);
		wait_vs(1'b0);
		wait_vs(1'b1);
	endtask

	// walks one frame from end of vsync to the last enable run
	task automatic check_frame();
		int         n, cyc, run_len, line_reads;
		logic       de_q;
		logic [11:0] idx;
		word_t      w;
		colour_t    exp_col;
		n = 0;
		cyc = 0;
		run_len = 0;
		line_reads = 0;
		de_q = 1'b0;
		frame_runs = 0;
		frame_reads = 0;
		bad_runs = 0;
		bad_lines = 0;
		while (frame_runs < 8 && cyc < 2000) begin
			@(negedge clk);
			cyc++;
			if (mem_read) begin
				if (frame_reads == 0)
					frame_first = vaddr;
				frame_reads++;
				line_reads++;
			end
			exp_col = '0;
			if (de) begin
				// pixel n is bit 15 - n mod 16 of word base + n / 16
				idx = 12'(exp_base + vaddr_t'(n / 16));
				w = mem_table[idx] << (n % 16);
				exp_col = {6{w[15] ^ exp_inv}};
				n++;
				run_len++;
			end else if (de_q) begin
				// end of a line with all its reads seen
				if (run_len != 64)
					bad_runs++;
				if (line_reads != 4)
					bad_lines++;
				frame_runs++;
				run_len = 0;
				line_reads = 0;
			end
			check_colour("video_r", video_r, exp_col);
			check_colour("video_g", video_g, exp_col);
			check_colour("video_b", video_b, exp_col);
			de_q = de;
		end
		if (frame_runs < 8) begin
			$display("timeout: only %0d display enable runs in a frame", frame_runs);
			$display("sim failed");
			$finish;
		end else begin
			frame_pix = n;
		end
	endtask

	// blank lines up to vsync stay dark
	// any enable or request there adds to the frame counts
	task automatic check_blank();
		int n;
		n = 0;
		while (vs !== 1'b0 && n < 2000) begin
			@(negedge clk);
			n++;
			if (de)
				frame_pix++;
			if (mem_read)
				frame_reads++;
			check_colour("video_r", video_r, '0);
			check_colour("video_g", video_g, '0);
			check_colour("video_b", video_b, '0);
		end
		if (vs !== 1'b0) begin
			$display("timeout: vs did not fall after the last display enable run");
			$display("sim failed");
			$finish;
		end
	endtask

	initial begin
		word_t     rd, d, hi, mid, lo;
		reg_addr_e a;
		int        i, f, hs_run, hs_falls, vs_low, vs_falls, last_fall;
		logic      hs_q, vs_q;
		void'($urandom(32'h923dd482));
		ss = 1'b1;
		reg_sel = 1'b0;
		reg_rw = 1'b1;
		reg_addr = '0;
		reg_din = '0;
		mem_data = '0;
		rd_q = 1'b0;
		errors = 0;
		mark = 0;
		tests = 0;
		for (i = 0; i < 4096; i++)
			mem_table[12'(i)] = word_t'($urandom);
		@(negedge clk);
		check_bit("de", de, 1'b0);
		check_bit("hs", hs, 1'b1);
		check_bit("vs", vs, 1'b1);
		@(negedge clk);
		ss = 1'b0;

		// reset values and then random writes with read-back
		reg_read(REG_BASE_HI, rd);
		check_word("reg_dout", rd, {8'h00, BASE_ADDR[22:15]});
		reg_read(REG_BASE_MID, rd);
		check_word("reg_dout", rd, {8'h00, BASE_ADDR[14:7]});
		reg_read(REG_PALETTE0, rd);
		check_word("reg_dout", rd, 16'h0007);
		for (i = 0; i < 9; i++) begin
			d = word_t'($urandom);
			a = (i % 3 == 0) ? REG_BASE_HI : (i % 3 == 1) ? REG_BASE_MID : REG_PALETTE0;
			reg_write(a, d);
			reg_read(a, rd);
			check_word("reg_dout", rd, d & ((a == REG_PALETTE0) ? 16'h0777 : 16'h00ff));
		end
		set_regs(vaddr_t'($urandom), 1'b0);
		end_test("register reset and read-back");

		// one whole frame of sync starting right after vsync
		next_frame();
		hs_run = 0;
		hs_falls = 0;
		vs_low = 0;
		vs_falls = 0;
		last_fall = 0;
		hs_q = hs;
		vs_q = vs;
		for (i = 0; i < 1536; i++) begin
			@(negedge clk);
			if (!hs) begin
				if (hs_q) begin
					if (hs_falls > 0)
						check_count("hs period", i - last_fall, 96);
					last_fall = i;
					hs_falls++;
				end
				hs_run++;
			end else if (!hs_q) begin
				check_count("hs low run", hs_run, 8);
				hs_run = 0;
			end
			if (!vs)
				vs_low++;
			if (!vs && vs_q)
				vs_falls++;
			hs_q = hs;
			vs_q = vs;
		end
		check_count("hs pulses", hs_falls, 16);
		check_count("vs low cycles", vs_low, 2 * 96);
		check_count("vs pulses", vs_falls, 1);
		end_test("sync shape");

		// frames alternate invert with a new base written in vertical blank
		next_frame();
		for (f = 0; f < 3; f++) begin
			check_frame();
			// still before vs falls with all 32 reads done
			reg_read(REG_CNT_HI, hi);
			reg_read(REG_CNT_MID, mid);
			reg_read(REG_CNT_LO, lo);
			check_bit("reg_dout bit 0", lo[0], 1'b0);
			check_addr("vaddr readback", {hi[7:0], mid[7:0], lo[7:1]}, exp_base + 23'd32);
			end_test("address counter read-back");
			check_blank();
			end_test("pixel content");
			check_count("de cycles", frame_pix, 64 * 8);
			check_count("de runs not 64 long", bad_runs, 0);
			end_test("display enable count");
			check_count("mem_read pulses", frame_reads, 32);
			check_count("lines without 4 reads", bad_lines, 0);
			check_addr("first vaddr", frame_first, exp_base);
			end_test("memory request pattern");
			// vsync has started and frame_end is still ahead
			set_regs(vaddr_t'($urandom), !f[0]);
			wait_vs(1'b1);
		end

		// bound fetch checks count their own failures
		errors += u_st_video.u_fetch.u_fetch_checks.fails;
		$display("%0d tests, %0d errors", tests, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule
